/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef logic [63:0] xlen_t;      // one data word
    typedef logic [4:0]  reg_addr_t;  // register index
    typedef logic [31:0] instr_t;     // raw instruction word
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes handled by the decoder
    localparam opcode_t OP_REG  = 7'b0110011;
    localparam opcode_t OP_IMM  = 7'b0010011;
    localparam opcode_t OP_LUI  = 7'b0110111;
    localparam opcode_t OP_LOAD = 7'b0000011;

    localparam funct3_t F3_ADD = 3'b000;  // also SUB and ADDI
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;
    localparam funct3_t F3_LD  = 3'b011;  // 64-bit load

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // selects SUB

endpackage

`default_nettype wire

/* rtl/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

    // operation carried from decode into execute
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLT   = 3'd5,
        ALU_PASSB = 3'd6   // LUI immediate or loaded word
    } alu_op_e;

    // load port of the execute stage
    typedef enum logic [1:0] {
        LD_IDLE = 2'd0,  // no bus cycle
        LD_WAIT = 2'd1,  // cyc/stb up, waiting for ack
        LD_DONE = 2'd2   // data captured, result valid
    } ld_state_e;

endpackage

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [63:0] rdata1,
    output logic [63:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [63:0] wdata
);

    logic [63:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero, same-cycle write is passed straight through
    function automatic logic [63:0] read_port(input logic [4:0] ra);
        if (ra == 5'd0) begin
            return '0;
        end else if (we && waddr == ra) begin
            return wdata;
        end
        return regs[ra];
    endfunction

    always_comb rdata1 = read_port(raddr1);
    always_comb rdata2 = read_port(raddr2);

    // the result stage filters rd == 0 before asking for a write
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n) !(we && waddr == 5'd0));

endmodule

`default_nettype wire

/* rtl/id_decode.sv */
`default_nettype none

module id_decode
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  instr_t    instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output xlen_t     imm,
    output alu_op_e   alu_op,
    output logic      is_load,
    output logic      illegal
);

    opcode_t opcode;
    funct3_t f3;
    funct7_t f7;
    xlen_t   imm_i;
    xlen_t   imm_u;
    logic    ok;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];
    assign imm_i  = {{52{instr[31]}}, instr[31:20]};
    assign imm_u  = {{32{instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        ok       = 1'b1;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm      = '0;
        alu_op   = ALU_ADD;
        is_load  = 1'b0;
        case (opcode)
            OP_REG: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case (f3)
                    F3_ADD:  alu_op = (f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: ok = 1'b0;
                endcase
                // only SUB may use the alternate funct7
                if (f7 != F7_BASE && !(f7 == F7_ALT && f3 == F3_ADD)) ok = 1'b0;
            end
            OP_IMM: begin
                uses_rs1 = 1'b1;
                imm      = imm_i;
                case (f3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: ok = 1'b0;  // SLTI and shifts not supported
                endcase
            end
            OP_LUI: begin
                imm    = imm_u;
                alu_op = ALU_PASSB;
            end
            OP_LOAD: begin
                uses_rs1 = 1'b1;
                imm      = imm_i;      // address offset
                alu_op   = ALU_PASSB;  // result is the loaded word
                is_load  = 1'b1;
                if (f3 != F3_LD) ok = 1'b0;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
            is_load  = 1'b0;
        end
    end

    assign illegal = !ok;
    assign rs1     = uses_rs1 ? instr[19:15] : '0;
    assign rs2     = uses_rs2 ? instr[24:20] : '0;
    assign rd      = ok ? instr[11:7] : '0;  // illegal word targets x0

endmodule

`default_nettype wire

/* rtl/hazard_stall.sv */
`default_nettype none

module hazard_stall
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      uses_rs1,
    input  logic      uses_rs2,
    input  logic      ex_valid,
    input  logic      ex_is_load,
    input  logic      ex_busy,
    input  reg_addr_t ex_rd,
    output logic      go
);

    logic      run_q;     // low until the first edge after reset
    logic      ld_ret_q;  // a load is in the result stage this cycle
    reg_addr_t ld_rd_q;   // its destination
    logic      ex_hit;
    logic      ret_hit;
    logic      stall;

    // decode source against the instruction in execute
    assign ex_hit = (ex_rd != '0) &&
                    ((uses_rs1 && rs1 == ex_rd) || (uses_rs2 && rs2 == ex_rd));

    // decode source against a load that just left execute
    assign ret_hit = (ld_rd_q != '0) &&
                     ((uses_rs1 && rs1 == ld_rd_q) || (uses_rs2 && rs2 == ld_rd_q));

    assign stall = instr_valid && ((ex_valid && ex_hit) || (ld_ret_q && ret_hit));
    assign go    = run_q && !ex_busy && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q    <= 1'b0;
            ld_ret_q <= 1'b0;
        end else begin
            run_q    <= 1'b1;
            ld_ret_q <= ex_valid && ex_is_load && !ex_busy;  // load leaving execute
        end
    end

    always_ff @(posedge clk) begin
        ld_rd_q <= ex_rd;
    end

    // a dependent instruction is held through the cycle its load retires
    a_hold_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && ex_valid && ex_is_load && !ex_busy && ex_hit)
        |=> !(go && instr_valid && $stable(rs1) && $stable(rs2)));

endmodule

`default_nettype wire

/* rtl/ex_alu.sv */
`default_nettype none

module ex_alu
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              accept,
    input  alu_op_e           alu_op,
    input  logic              is_load,
    input  logic              illegal,
    input  reg_addr_t         rd,
    input  xlen_t             rs1_val,
    input  xlen_t             rs2_val,
    input  xlen_t             imm,
    input  logic              use_imm,
    output logic              ex_valid,
    output logic              ex_is_load,
    output logic              ex_busy,
    output logic              ex_done,
    output logic              ex_illegal,
    output reg_addr_t         ex_rd,
    output xlen_t             ex_result,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic [ADDR_W-1:0] wb_adr,
    input  xlen_t             wb_dat_i,
    input  logic              wb_ack
);

    ld_state_e         state_q;
    logic              valid_q;
    alu_op_e           op_q;
    reg_addr_t         rd_q;
    logic              is_load_q;
    logic              illegal_q;
    xlen_t             a_q;
    xlen_t             b_q;      // immediate, rs2, or loaded word
    logic [ADDR_W-1:0] adr_q;
    xlen_t             ea;

    assign ea = rs1_val + imm;  // load effective address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LD_IDLE;
            valid_q <= 1'b0;
        end else if (state_q == LD_WAIT) begin
            if (wb_ack) state_q <= LD_DONE;
        end else begin
            valid_q <= accept;
            state_q <= (accept && is_load) ? LD_WAIT : LD_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= alu_op;
            rd_q      <= rd;
            is_load_q <= is_load;
            illegal_q <= illegal;
            a_q       <= rs1_val;
            b_q       <= use_imm ? imm : rs2_val;
            adr_q     <= ea[ADDR_W-1:0];
        end else if (state_q == LD_WAIT && wb_ack) begin
            b_q <= wb_dat_i;  // PASSB then forwards it as the result
        end
    end

    always_comb begin
        case (op_q)
            ALU_ADD:   ex_result = a_q + b_q;
            ALU_SUB:   ex_result = a_q - b_q;
            ALU_AND:   ex_result = a_q & b_q;
            ALU_OR:    ex_result = a_q | b_q;
            ALU_XOR:   ex_result = a_q ^ b_q;
            ALU_SLT:   ex_result = {63'b0, $signed(a_q) < $signed(b_q)};
            ALU_PASSB: ex_result = b_q;
            default:   ex_result = '0;
        endcase
    end

    assign ex_valid   = valid_q;
    assign ex_is_load = is_load_q;
    assign ex_busy    = (state_q == LD_WAIT);
    assign ex_done    = valid_q && (state_q == LD_DONE || !is_load_q);
    assign ex_illegal = illegal_q;
    assign ex_rd      = rd_q;

    assign wb_cyc = (state_q == LD_WAIT);
    assign wb_stb = (state_q == LD_WAIT);
    assign wb_adr = adr_q;

    // an instruction accepted during a bus cycle would be lost
    a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ex_busy |-> !accept);

    // classic cycle holds request and address until ack
    a_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)));

endmodule

`default_nettype wire

/* rtl/result_stage.sv */
`default_nettype none

module result_stage
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ex_done,
    input  logic      ex_illegal,
    input  reg_addr_t ex_rd,
    input  xlen_t     ex_result,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output xlen_t     rf_wdata,
    output logic      ret_valid,
    output logic      ret_illegal,
    output reg_addr_t ret_rd,
    output xlen_t     ret_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_valid <= 1'b0;
            rf_we     <= 1'b0;
        end else begin
            ret_valid <= ex_done;                                   // one pulse per result
            rf_we     <= ex_done && !ex_illegal && ex_rd != '0;     // x0 and illegal drop out
        end
    end

    always_ff @(posedge clk) begin
        if (ex_done) begin
            ret_rd      <= ex_rd;
            ret_data    <= ex_illegal ? '0 : ex_result;
            ret_illegal <= ex_illegal;
        end
    end

    // the retire record doubles as the write port
    assign rf_waddr = ret_rd;
    assign rf_wdata = ret_data;

endmodule

`default_nettype wire

/* rtl/core_top.sv */
`default_nettype none

module core_top
    import rv_isa_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  instr_t            instr,
    output logic              instr_ready,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic [ADDR_W-1:0] wb_adr,
    input  xlen_t             wb_dat_i,
    input  logic              wb_ack,
    output logic              ret_valid,
    output reg_addr_t         ret_rd,
    output xlen_t             ret_data,
    output logic              ret_illegal
);

    reg_addr_t              rs1, rs2, rd, ex_rd, rf_waddr;
    logic                   uses_rs1, uses_rs2, is_load, illegal;
    xlen_t                  imm, rs1_val, rs2_val, ex_result, rf_wdata;
    core_ctrl_pkg::alu_op_e alu_op;
    logic                   accept, use_imm;
    logic                   ex_valid, ex_is_load, ex_busy, ex_done, ex_illegal;
    logic                   rf_we;

    assign accept  = instr_valid && instr_ready;
    assign use_imm = !uses_rs2;  // every form without rs2 takes the immediate

    id_decode u_decode (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd),
        .uses_rs1(uses_rs1), .uses_rs2(uses_rs2), .imm(imm),
        .alu_op(alu_op), .is_load(is_load), .illegal(illegal)
    );

    hazard_stall u_hazard (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid),
        .rs1(rs1), .rs2(rs2), .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
        .ex_valid(ex_valid), .ex_is_load(ex_is_load), .ex_busy(ex_busy),
        .ex_rd(ex_rd), .go(instr_ready)
    );

    reg_file u_regs (
        .clk(clk), .rst_n(rst_n), .raddr1(rs1), .raddr2(rs2),
        .rdata1(rs1_val), .rdata2(rs2_val),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    ex_alu #(.ADDR_W(ADDR_W)) u_ex (
        .clk(clk), .rst_n(rst_n), .accept(accept), .alu_op(alu_op),
        .is_load(is_load), .illegal(illegal), .rd(rd),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .use_imm(use_imm),
        .ex_valid(ex_valid), .ex_is_load(ex_is_load), .ex_busy(ex_busy),
        .ex_done(ex_done), .ex_illegal(ex_illegal), .ex_rd(ex_rd),
        .ex_result(ex_result), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    result_stage u_result (
        .clk(clk), .rst_n(rst_n), .ex_done(ex_done), .ex_illegal(ex_illegal),
        .ex_rd(ex_rd), .ex_result(ex_result),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .ret_valid(ret_valid), .ret_illegal(ret_illegal),
        .ret_rd(ret_rd), .ret_data(ret_data)
    );

endmodule

`default_nettype wire

/* verif/tb_core.sv */
`default_nettype none

module tb_core;

    localparam int RESET_CYC = 16;
    localparam int N_INSTR   = 66;   // instructions issued over all tests

    localparam logic [2:0] F_ADD = 3'b000;
    localparam logic [2:0] F_SLT = 3'b010;
    localparam logic [2:0] F_XOR = 3'b100;
    localparam logic [2:0] F_OR  = 3'b110;
    localparam logic [2:0] F_AND = 3'b111;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [63:0] wb_dat_i = '0;
    logic        wb_ack = 1'b0;
    logic        ret_valid;
    logic [4:0]  ret_rd;
    logic [63:0] ret_data;
    logic        ret_illegal;

    logic [63:0] model [32];    // reference register file, x0 never written
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_data [$];
    bit          exp_ill [$];
    logic [31:0] exp_adr [$];   // one entry per LD still to reach the bus
    logic [4:0]  e_rd;
    logic [63:0] e_data;
    bit          e_ill;
    logic [31:0] e_adr;
    int          errors = 0;
    int          issued = 0;
    int          retired = 0;
    int          loads = 0;
    int          bus_cycles = 0;
    int          wait_left = 0;

    core_top #(.ADDR_W(32)) UUT (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .instr_ready(instr_ready), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack), .ret_valid(ret_valid), .ret_rd(ret_rd),
        .ret_data(ret_data), .ret_illegal(ret_illegal)
    );

    always #10 clk = ~clk;

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] mem_word(input logic [31:0] a);
        return {32'b0, a} * 64'h9E3779B97F4A7C15;
    endfunction

    // RV64I integer semantics for the kept funct3 codes
    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input bit sub,
                                            input logic [63:0] a, input logic [63:0] b);
        case (f3)
            F_ADD:   return sub ? a - b : a + b;
            F_SLT:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            F_XOR:   return a ^ b;
            F_OR:    return a | b;
            F_AND:   return a & b;
            default: return '0;
        endcase
    endfunction

    // queue the expected record, then hold the word on the port until accepted
    task automatic send(input logic [31:0] word, input logic [4:0] rd,
                        input logic [63:0] value, input bit bad);
        exp_rd.push_back(rd);
        exp_data.push_back(value);
        exp_ill.push_back(bad);
        if (!bad && rd != 5'd0) model[rd] = value;
        issued++;
        @(negedge clk);
        instr       = word;
        instr_valid = 1'b1;
        do @(posedge clk); while (!instr_ready);
    endtask

    task automatic op_r(input logic [2:0] f3, input bit sub, input int rd, input int rs1,
                        input int rs2);
        logic [6:0] f7;
        f7 = sub ? 7'b0100000 : 7'b0000000;
        send({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011}, rd[4:0],
             alu_ref(f3, sub, model[rs1[4:0]], model[rs2[4:0]]), 1'b0);
    endtask

    task automatic op_i(input logic [2:0] f3, input int rd, input int rs1, input int imm);
        send({imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011}, rd[4:0],
             alu_ref(f3, 1'b0, model[rs1[4:0]], sext12(imm[11:0])), 1'b0);
    endtask

    task automatic op_lui(input int rd, input int imm);
        send({imm[19:0], rd[4:0], 7'b0110111}, rd[4:0],
             {{32{imm[19]}}, imm[19:0], 12'b0}, 1'b0);
    endtask

    task automatic op_ld(input int rd, input int rs1, input int imm);
        logic [63:0] sum;
        sum = model[rs1[4:0]] + sext12(imm[11:0]);
        exp_adr.push_back(sum[31:0]);   // bus address is truncated to 32 bits
        loads++;
        send({imm[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011}, rd[4:0],
             mem_word(sum[31:0]), 1'b0);
    endtask

    task automatic gap(input int n);
        @(negedge clk);
        instr_valid = 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_rd.size() != 0) @(negedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int err0);
        $display("test %0d %s: done, %0d errors", num, name, errors - err0);
    endtask

    task automatic test_independent();
        int err0;
        err0 = errors;
        op_lui(1, 'h80000);            // sign extends into the upper word
        op_i(F_ADD, 2, 0, -5);
        op_i(F_ADD, 3, 0, 7);
        op_lui(4, 'h12345);
        op_r(F_SLT, 1'b0, 5, 2, 3);    // negative against positive
        op_r(F_ADD, 1'b1, 6, 0, 3);    // wraps below zero
        op_r(F_SLT, 1'b0, 7, 3, 2);
        op_i(F_XOR, 8, 1, -1);
        op_i(F_AND, 9, 2, 'h0F0);
        op_r(F_OR, 1'b0, 10, 1, 4);
        op_r(F_AND, 1'b0, 11, 2, 1);
        op_r(F_ADD, 1'b0, 12, 1, 1);
        op_r(F_SLT, 1'b0, 13, 1, 3);
        op_r(F_XOR, 1'b0, 14, 4, 2);
        drain();
        report_test(1, "alu_independent", err0);
    endtask

    task automatic test_chain();
        int err0;
        err0 = errors;
        op_i(F_ADD, 15, 0, 1);
        for (int k = 0; k < 6; k++) begin
            op_r(F_ADD, 1'b0, 15, 15, 15);
        end
        op_i(F_ADD, 16, 15, -3);
        op_r(F_ADD, 1'b1, 17, 16, 15);
        op_r(F_XOR, 1'b0, 18, 17, 16);
        op_r(F_OR, 1'b0, 19, 18, 17);
        op_r(F_AND, 1'b0, 20, 19, 16);
        op_r(F_SLT, 1'b0, 21, 20, 19);
        op_r(F_ADD, 1'b1, 15, 21, 15);
        drain();
        report_test(2, "alu_chain", err0);
    endtask

    task automatic test_load_use();
        int err0;
        err0 = errors;
        op_lui(22, 'h10);
        op_i(F_ADD, 22, 22, 'h40);
        op_ld(23, 22, 8);
        op_r(F_ADD, 1'b0, 24, 23, 23);  // uses the load right away
        op_ld(25, 22, -16);
        op_r(F_XOR, 1'b0, 26, 25, 23);
        op_ld(27, 23, 4);               // base is a loaded 64-bit word
        op_r(F_ADD, 1'b1, 28, 27, 25);
        op_ld(23, 27, 0);
        op_i(F_ADD, 23, 23, 1);
        for (int k = 0; k < 4; k++) begin
            op_ld(29, 22, k * 8);
            op_r(F_ADD, 1'b0, 30, 29, 30);
        end
        drain();
        report_test(3, "load_use", err0);
    endtask

    task automatic test_bus_cycles();
        int err0;
        int c0;
        err0 = errors;
        c0   = bus_cycles;
        op_ld(1, 22, 0);
        op_ld(2, 22, 8);
        op_ld(3, 22, 24);
        op_r(F_ADD, 1'b0, 4, 1, 2);
        drain();
        assert (bus_cycles - c0 == 3) else begin
            $display("expected 3 bus cycles for 3 loads, saw %0d", bus_cycles - c0);
            errors++;
        end
        report_test(4, "bus_cycles", err0);
    endtask

    task automatic test_x0_illegal();
        int err0;
        err0 = errors;
        op_i(F_ADD, 0, 0, 5);
        op_r(F_ADD, 1'b0, 1, 0, 0);
        op_lui(0, 'hABCDE);
        op_i(F_ADD, 5, 0, 0);
        send(32'hFFFF_FFFF, 5'd0, '0, 1'b1);                                 // unknown opcode
        send({12'h001, 5'd1, 3'b010, 5'd6, 7'b0010011}, 5'd0, '0, 1'b1);     // SLTI
        send({12'h000, 5'd22, 3'b010, 5'd7, 7'b0000011}, 5'd0, '0, 1'b1);    // LW
        send({7'b0000001, 5'd2, 5'd3, 3'b000, 5'd8, 7'b0110011}, 5'd0, '0, 1'b1);  // MUL
        op_r(F_ADD, 1'b0, 9, 6, 7);
        op_r(F_OR, 1'b0, 10, 8, 6);
        op_ld(11, 0, 'h100);
        drain();
        report_test(5, "x0_and_illegal", err0);
    endtask

    task automatic test_valid_gaps();
        int err0;
        err0 = errors;
        op_i(F_ADD, 12, 0, 100);
        gap(3);
        op_i(F_ADD, 12, 12, 1);
        gap(1);
        op_r(F_ADD, 1'b0, 13, 12, 12);
        gap(5);
        op_ld(14, 22, 32);
        gap(2);
        op_r(F_OR, 1'b0, 15, 14, 13);
        drain();
        assert (retired == issued) else begin
            $display("retired %0d instructions but issued %0d", retired, issued);
            errors++;
        end
        report_test(6, "valid_gaps", err0);
    endtask

    // Wishbone slave with 0 to 3 wait states, ack only inside an open cycle
    initial begin
        void'($urandom(4331));
        forever begin
            @(negedge clk);
            if (rst_n && wb_cyc && wb_stb) begin
                if (wait_left == 0) begin
                    wb_ack   = 1'b1;
                    wb_dat_i = mem_word(wb_adr);
                end else begin
                    wait_left = wait_left - 1;
                end
            end else begin
                wb_ack    = 1'b0;
                wait_left = $urandom % 4;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            assert (!wb_stb || wb_cyc) else begin
                $display("wb_stb high without wb_cyc");
                errors++;
            end
            assert (!wb_cyc || !instr_ready) else begin
                $display("instr_ready high while a load bus cycle is open");
                errors++;
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                bus_cycles++;
                if (exp_adr.size() == 0) begin
                    $display("bus cycle ended with no load outstanding");
                    errors++;
                end else begin
                    e_adr = exp_adr.pop_front();
                    assert (wb_adr == e_adr) else begin
                        $display("** Error: wb_adr expected %h got %h", e_adr, wb_adr);
                        errors++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && ret_valid) begin
            retired++;
            if (exp_rd.size() == 0) begin
                $display("retire pulse with no instruction outstanding");
                errors++;
            end else begin
                e_rd   = exp_rd.pop_front();
                e_data = exp_data.pop_front();
                e_ill  = exp_ill.pop_front();
                assert (ret_illegal == e_ill) else begin
                    $display("** Error: ret_illegal expected %h got %h", e_ill, ret_illegal);
                    errors++;
                end
                assert (ret_rd == e_rd) else begin
                    $display("** Error: ret_rd expected %h got %h", e_rd, ret_rd);
                    errors++;
                end
                if (!e_ill) begin
                    assert (ret_data == e_data) else begin
                        $display("** Error: ret_data expected %h got %h", e_data, ret_data);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        repeat (RESET_CYC + N_INSTR * 40) @(posedge clk);
        $display("watchdog expired after %0d instructions issued, %0d retired", issued, retired);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_independent();
        test_chain();
        test_load_use();
        test_bus_cycles();
        test_x0_illegal();
        test_valid_gaps();
        assert (bus_cycles == loads) else begin
            $display("saw %0d bus cycles for %0d loads", bus_cycles, loads);
            errors++;
        end
        $display("6 tests, %0d issued, %0d retired, %0d bus cycles, %0d errors",
                 issued, retired, bus_cycles, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/rv_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/reg_file.sv
rtl/id_decode.sv
rtl/hazard_stall.sv
rtl/ex_alu.sv
rtl/result_stage.sv
rtl/core_top.sv
verif/tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
